//--- design/icmp_echo_tx_params.svh
`ifndef ICMP_ECHO_TX_PARAMS_SVH
`define ICMP_ECHO_TX_PARAMS_SVH

// **********************************************************************
// station addresses
// **********************************************************************
`define BOARD_MAC           48'ha0_b1_c2_d3_e1_e1
`define BOARD_IP            32'hc0_a8_01_0b        // 192.168.1.11

// used when the request leaves an address at zero
`define DEFAULT_DES_MAC     48'h84_a9_38_bf_c9_a0
`define DEFAULT_DES_IP      32'ha9_fe_33_78        // 169.254.51.120

// **********************************************************************
// frame layout
// **********************************************************************
`define ETH_TYPE_IPV4       16'h0800
`define PREAMBLE_BYTES      8                      // seven 0x55 then 0xd5
`define ETH_HEAD_BYTES      14
`define IP_ICMP_HEAD_BYTES  28                     // 20 ip + 8 icmp
`define MIN_PAYLOAD_BYTES   18                     // 46 byte minimum less 28

// ip and icmp field values
`define IP_TTL              8'h80
`define IP_PROTO_ICMP       8'h01
`define ICMP_ECHO_REPLY     8'h00

`endif

//--- design/icmp_echo_tx_pkg.sv
package icmp_echo_tx_pkg;

    // one echo-reply request, held by the caller until tx_done
    typedef struct packed {
        logic [47:0] des_mac;
        logic [31:0] des_ip;
        logic [15:0] icmp_id;
        logic [15:0] icmp_seq;
        logic [31:0] pay_sum;    // sum of the payload's 16-bit words
        logic [15:0] pay_len;    // payload bytes before padding
    } frame_req_t;

    // one byte slot on the gmii side
    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } gmii_beat_t;

    // transmit sequence, in the order the phases run
    typedef enum logic [2:0] {
        ph_idle,
        ph_checksum,    // both header sums run side by side
        ph_preamble,
        ph_eth_head,
        ph_ip_head,     // ip header followed by the icmp header
        ph_payload,
        ph_pad,         // zero bytes up to the ethernet minimum
        ph_fcs
    } tx_phase_e;

endpackage

//--- design/icmp_echo_tx_ctrl.sv
`timescale 1ns/1ps
`include "icmp_echo_tx_params.svh"

module icmp_echo_tx_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tx_start_en,
    input  logic [15:0]                 payload_len,
    output icmp_echo_tx_pkg::tx_phase_e phase,
    output logic [4:0]                  byte_idx,
    output logic                        load,
    output logic                        csum_start,
    output logic                        tx_req,
    output logic                        tx_done
);

    logic        start_d;        // tx_start_en one clock late
    logic        start_pulse;
    logic [15:0] pay_cnt;        // payload plus pad bytes so far
    logic        last_pay;       // final payload byte this cycle
    logic        short_frame;    // payload below the ethernet minimum
    logic        done_d;

    // **********************************************************************
    // start edge and load
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d     <= 1'b0;
            start_pulse <= 1'b0;
            load        <= 1'b0;
        end else begin
            start_d     <= tx_start_en;
            start_pulse <= tx_start_en & ~start_d;
            // edges landing in a running frame die here
            load        <= start_pulse && (phase == icmp_echo_tx_pkg::ph_idle);
        end
    end

    assign last_pay    = (pay_cnt == payload_len - 16'd1);
    assign short_frame = (payload_len < 16'(`MIN_PAYLOAD_BYTES));

    // **********************************************************************
    // phase sequencer
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= icmp_echo_tx_pkg::ph_idle;
            byte_idx <= '0;
            pay_cnt  <= '0;
        end else begin
            byte_idx <= byte_idx + 5'd1;
            case (phase)
                icmp_echo_tx_pkg::ph_idle: begin
                    byte_idx <= '0;
                    if (load) begin
                        phase <= icmp_echo_tx_pkg::ph_checksum;
                    end
                end
                icmp_echo_tx_pkg::ph_checksum: begin
                    if (byte_idx == 5'd3) begin    // start, sum, fold, fold
                        byte_idx <= '0;
                        phase    <= icmp_echo_tx_pkg::ph_preamble;
                    end
                end
                icmp_echo_tx_pkg::ph_preamble: begin
                    if (byte_idx == 5'(`PREAMBLE_BYTES - 1)) begin
                        byte_idx <= '0;
                        phase    <= icmp_echo_tx_pkg::ph_eth_head;
                    end
                end
                icmp_echo_tx_pkg::ph_eth_head: begin
                    if (byte_idx == 5'(`ETH_HEAD_BYTES - 1)) begin
                        byte_idx <= '0;
                        phase    <= icmp_echo_tx_pkg::ph_ip_head;
                    end
                end
                icmp_echo_tx_pkg::ph_ip_head: begin
                    pay_cnt <= '0;
                    if (byte_idx == 5'(`IP_ICMP_HEAD_BYTES - 1)) begin
                        byte_idx <= '0;
                        if (payload_len == 16'd0) begin
                            phase <= icmp_echo_tx_pkg::ph_pad;
                        end else begin
                            phase <= icmp_echo_tx_pkg::ph_payload;
                        end
                    end
                end
                icmp_echo_tx_pkg::ph_payload: begin
                    byte_idx <= '0;
                    pay_cnt  <= pay_cnt + 16'd1;
                    if (last_pay) begin
                        if (short_frame) begin
                            phase <= icmp_echo_tx_pkg::ph_pad;
                        end else begin
                            phase <= icmp_echo_tx_pkg::ph_fcs;
                        end
                    end
                end
                icmp_echo_tx_pkg::ph_pad: begin
                    byte_idx <= '0;
                    pay_cnt  <= pay_cnt + 16'd1;    // keeps counting from the payload
                    if (pay_cnt == 16'(`MIN_PAYLOAD_BYTES - 1)) begin
                        phase <= icmp_echo_tx_pkg::ph_fcs;
                    end
                end
                icmp_echo_tx_pkg::ph_fcs: begin
                    if (byte_idx == 5'd3) begin
                        byte_idx <= '0;
                        phase    <= icmp_echo_tx_pkg::ph_idle;
                    end
                end
                default: phase <= icmp_echo_tx_pkg::ph_idle;
            endcase
        end
    end

    assign csum_start = (phase == icmp_echo_tx_pkg::ph_checksum) && (byte_idx == 5'd0);

    // request one byte ahead, last ip byte through the next to last payload byte
    assign tx_req = ((phase == icmp_echo_tx_pkg::ph_ip_head)
                     && (byte_idx == 5'(`IP_ICMP_HEAD_BYTES - 1))
                     && (payload_len != 16'd0))
                    || ((phase == icmp_echo_tx_pkg::ph_payload) && !last_pay);

    // done trails the last fcs byte on the gmii pins by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_d  <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            done_d  <= (phase == icmp_echo_tx_pkg::ph_fcs) && (byte_idx == 5'd3);
            tx_done <= done_d;
        end
    end

    // every requested byte is consumed by the payload phase one cycle later
    assert property (@(posedge clk) disable iff (!rst_n)
        tx_req |=> (phase == icmp_echo_tx_pkg::ph_payload))
        else $error("tx_req not followed by a payload phase cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        (phase == icmp_echo_tx_pkg::ph_idle) && !load |=> (phase == icmp_echo_tx_pkg::ph_idle))
        else $error("phase left idle without load");

endmodule

//--- design/ones_sum_fold.sv
`timescale 1ns/1ps

module ones_sum_fold #(
    parameter int WORDS = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [WORDS*16-1:0] words,
    output logic [15:0]         csum
);

    logic [31:0] word_sum;
    logic [31:0] acc;

    // plain sum of all 16-bit words, carries pile up in the top half
    always_comb begin
        word_sum = '0;
        for (int i = 0; i < WORDS; i++) begin
            word_sum = word_sum + 32'(words[i*16 +: 16]);
        end
    end

    // start loads the raw sum, each later cycle folds the carries back in.
    // two folds settle it and the upper half then stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (start) begin
            acc <= word_sum;
        end else begin
            acc <= {16'h0000, acc[31:16]} + {16'h0000, acc[15:0]};
        end
    end

    assign csum = ~acc[15:0];    // valid from the third cycle after start

endmodule

//--- design/frame_header_gen.sv
`timescale 1ns/1ps
`include "icmp_echo_tx_params.svh"

module frame_header_gen (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,
    input  logic                         csum_done,
    input  icmp_echo_tx_pkg::frame_req_t req,
    input  icmp_echo_tx_pkg::tx_phase_e  phase,
    input  logic [4:0]                   byte_idx,
    output logic [159:0]                 ip_words,
    output logic [63:0]                  icmp_words,
    input  logic [15:0]                  ip_csum,
    input  logic [15:0]                  icmp_csum,
    output logic [7:0]                   head_byte
);

    icmp_echo_tx_pkg::frame_req_t req_q;    // request with addresses resolved
    logic [15:0]  ident;
    logic [15:0]  ip_csum_q;
    logic [15:0]  icmp_csum_q;
    logic [15:0]  total_len;
    logic [111:0] eth_hdr;
    logic [223:0] ip_icmp_hdr;

    always_ff @(posedge clk) begin
        if (load) begin
            req_q         <= req;
            req_q.des_mac <= (req.des_mac != 48'd0) ? req.des_mac : `DEFAULT_DES_MAC;
            req_q.des_ip  <= (req.des_ip != 32'd0) ? req.des_ip : `DEFAULT_DES_IP;
        end
        if (csum_done) begin
            ip_csum_q   <= ip_csum;
            icmp_csum_q <= icmp_csum;
        end
    end

    // identification, first frame after reset carries 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ident <= '0;
        end else if (load) begin
            ident <= ident + 16'd1;
        end
    end

    assign total_len = req_q.pay_len + 16'(`IP_ICMP_HEAD_BYTES);    // padding not counted

    // **********************************************************************
    // checksum words, checksum fields taken as zero
    // **********************************************************************
    assign ip_words = {8'h45, 8'h00, total_len,
                       ident, 16'h4000,              // don't fragment
                       `IP_TTL, `IP_PROTO_ICMP, 16'h0000,
                       `BOARD_IP, req_q.des_ip};

    // type and code of an echo reply are both zero and add nothing
    assign icmp_words = {req_q.icmp_id, req_q.icmp_seq, req_q.pay_sum};

    // **********************************************************************
    // header bytes, big endian
    // **********************************************************************
    assign eth_hdr = {req_q.des_mac, `BOARD_MAC, `ETH_TYPE_IPV4};

    assign ip_icmp_hdr = {ip_words[159:80], ip_csum_q, ip_words[63:0],
                          `ICMP_ECHO_REPLY, 8'h00, icmp_csum_q,
                          req_q.icmp_id, req_q.icmp_seq};

    always_comb begin
        case (phase)
            icmp_echo_tx_pkg::ph_eth_head:
                head_byte = eth_hdr[8*(`ETH_HEAD_BYTES - 1 - byte_idx) +: 8];
            icmp_echo_tx_pkg::ph_ip_head:
                head_byte = ip_icmp_hdr[8*(`IP_ICMP_HEAD_BYTES - 1 - byte_idx) +: 8];
            default:
                head_byte = 8'h00;
        endcase
    end

    // the sequencer never indexes past the header being sent
    assert property (@(posedge clk) disable iff (!rst_n)
        (phase inside {icmp_echo_tx_pkg::ph_eth_head, icmp_echo_tx_pkg::ph_ip_head})
        |-> (byte_idx < ((phase == icmp_echo_tx_pkg::ph_eth_head) ?
                         `ETH_HEAD_BYTES : `IP_ICMP_HEAD_BYTES)))
        else $error("header index %0d out of range", byte_idx);

endmodule

//--- design/eth_fcs_gen.sv
`timescale 1ns/1ps

module eth_fcs_gen (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,      // restart before a new frame
    input  logic       en,         // data holds a frame byte this cycle
    input  logic [7:0] data,
    input  logic [1:0] fcs_idx,
    output logic [7:0] fcs_byte
);

    localparam logic [31:0] crc_poly_rev = 32'hedb8_8320;    // 0x04c11db7 bit reversed

    logic [31:0] crc;

    // one byte through the reflected crc, lsb first as on the wire
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ crc_poly_rev;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '1;
        end else if (clear) begin
            crc <= '1;
        end else if (en) begin
            crc <= crc_byte(crc, data);
        end
    end

    // complemented residue, low byte first
    assign fcs_byte = ~crc[8*fcs_idx +: 8];

    // the load pulse comes well before the first header byte
    assert property (@(posedge clk) disable iff (!rst_n) !(clear && en))
        else $error("fcs clear and update in the same cycle");

endmodule

//--- design/icmp_echo_tx.sv
`timescale 1ns/1ps
`include "icmp_echo_tx_params.svh"

module icmp_echo_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start_en,
    input  logic [31:0] reply_checksum,
    input  logic [15:0] icmp_id,
    input  logic [15:0] icmp_seq,
    input  logic [15:0] tx_byte_num,
    input  logic [47:0] des_mac,
    input  logic [31:0] des_ip,
    input  logic [7:0]  tx_data,
    output logic        tx_req,
    output logic        tx_done,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd
);

    icmp_echo_tx_pkg::frame_req_t req;
    icmp_echo_tx_pkg::tx_phase_e  phase;
    icmp_echo_tx_pkg::gmii_beat_t beat_next;
    icmp_echo_tx_pkg::gmii_beat_t beat_q;
    logic [4:0]   byte_idx;
    logic         load;
    logic         csum_start;
    logic         csum_done;
    logic         fcs_en;
    logic [159:0] ip_words;
    logic [63:0]  icmp_words;
    logic [15:0]  ip_csum;
    logic [15:0]  icmp_csum;
    logic [7:0]   head_byte;
    logic [7:0]   fcs_byte;

    assign req = '{des_mac:  des_mac,
                   des_ip:   des_ip,
                   icmp_id:  icmp_id,
                   icmp_seq: icmp_seq,
                   pay_sum:  reply_checksum,
                   pay_len:  tx_byte_num};

    icmp_echo_tx_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .payload_len (tx_byte_num),
        .phase       (phase),
        .byte_idx    (byte_idx),
        .load        (load),
        .csum_start  (csum_start),
        .tx_req      (tx_req),
        .tx_done     (tx_done)
    );

    // last checksum cycle, both sums have settled
    assign csum_done = (phase == icmp_echo_tx_pkg::ph_checksum) && (byte_idx == 5'd3);

    frame_header_gen u_header (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .csum_done  (csum_done),
        .req        (req),
        .phase      (phase),
        .byte_idx   (byte_idx),
        .ip_words   (ip_words),
        .icmp_words (icmp_words),
        .ip_csum    (ip_csum),
        .icmp_csum  (icmp_csum),
        .head_byte  (head_byte)
    );

    ones_sum_fold #(.WORDS(10)) ip_csum_u (
        .clk   (clk),
        .rst_n (rst_n),
        .start (csum_start),
        .words (ip_words),
        .csum  (ip_csum)
    );

    ones_sum_fold #(.WORDS(4)) icmp_csum_u (
        .clk   (clk),
        .rst_n (rst_n),
        .start (csum_start),
        .words (icmp_words),
        .csum  (icmp_csum)
    );

    // **********************************************************************
    // beat select and gmii output register
    // **********************************************************************
    always_comb begin
        beat_next.en = 1'b1;
        case (phase)
            icmp_echo_tx_pkg::ph_preamble:
                beat_next.data = (byte_idx == 5'(`PREAMBLE_BYTES - 1)) ? 8'hd5 : 8'h55;
            icmp_echo_tx_pkg::ph_eth_head,
            icmp_echo_tx_pkg::ph_ip_head:
                beat_next.data = head_byte;
            icmp_echo_tx_pkg::ph_payload: beat_next.data = tx_data;    // requested last cycle
            icmp_echo_tx_pkg::ph_pad:     beat_next.data = 8'h00;
            icmp_echo_tx_pkg::ph_fcs:     beat_next.data = fcs_byte;
            default: begin
                beat_next.en   = 1'b0;
                beat_next.data = 8'h00;
            end
        endcase
    end

    // crc covers everything from the ethernet header through the pad
    assign fcs_en = phase inside {icmp_echo_tx_pkg::ph_eth_head, icmp_echo_tx_pkg::ph_ip_head,
                                  icmp_echo_tx_pkg::ph_payload, icmp_echo_tx_pkg::ph_pad};

    eth_fcs_gen u_fcs (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (load),
        .en       (fcs_en),
        .data     (beat_next.data),
        .fcs_idx  (byte_idx[1:0]),
        .fcs_byte (fcs_byte)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else begin
            beat_q <= beat_next;
        end
    end

    assign gmii_tx_en = beat_q.en;
    assign gmii_txd   = beat_q.data;

endmodule

//--- verification/icmp_echo_tx_ref.svh
`ifndef ICMP_ECHO_TX_REF_SVH
`define ICMP_ECHO_TX_REF_SVH

// payload as big-endian 16-bit words, an odd tail byte fills the high half
function automatic logic [31:0] payload_word_sum(input int n);
    logic [31:0] s;
    s = 32'd0;
    for (int k = 0; k < n; k += 2) begin
        if (k + 1 < n) begin
            s = s + {16'h0000, payload[k], payload[k + 1]};
        end else begin
            s = s + {16'h0000, payload[k], 8'h00};
        end
    end
    return s;
endfunction

// end-around carry until nothing is left above bit 15, then invert
function automatic logic [15:0] fold_invert(input logic [31:0] s);
    logic [31:0] r;
    r = s;
    while (r[31:16] != 16'h0000) begin
        r = {16'h0000, r[31:16]} + {16'h0000, r[15:0]};
    end
    return ~r[15:0];
endfunction

// msb-first crc-32, each wire bit goes in lsb first
function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
        if (r[31] ^ d[i]) begin
            r = (r << 1) ^ 32'h04c1_1db7;
        end else begin
            r = r << 1;
        end
    end
    return r;
endfunction

function automatic logic [31:0] reflect32(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
        r[i] = v[31 - i];
    end
    return r;
endfunction

// queues the whole frame as it should appear on gmii_txd
function automatic void expect_frame(input logic [47:0] mac, input logic [31:0] ip,
                                     input logic [15:0] id, input logic [15:0] seq,
                                     input int n, input logic [15:0] ident);
    logic [7:0]   body [0:299];
    logic [111:0] eth;
    logic [159:0] iph;
    logic [63:0]  icmph;
    logic [31:0]  s;
    logic [31:0]  crc;
    logic [31:0]  fcs;
    int           len;
    eth = {((mac != 48'd0) ? mac : `DEFAULT_DES_MAC), `BOARD_MAC, `ETH_TYPE_IPV4};
    iph = {8'h45, 8'h00, 16'(n + `IP_ICMP_HEAD_BYTES), ident, 16'h4000,
           `IP_TTL, `IP_PROTO_ICMP, 16'h0000,
           `BOARD_IP, ((ip != 32'd0) ? ip : `DEFAULT_DES_IP)};
    s = 32'd0;
    for (int i = 0; i < 10; i++) begin
        s = s + {16'h0000, iph[16*i +: 16]};
    end
    iph[79:64] = fold_invert(s);    // header checksum word
    icmph = {`ICMP_ECHO_REPLY, 8'h00, 16'h0000, id, seq};
    s = payload_word_sum(n);
    for (int i = 0; i < 4; i++) begin
        s = s + {16'h0000, icmph[16*i +: 16]};
    end
    icmph[47:32] = fold_invert(s);
    for (int i = 0; i < 14; i++) begin
        body[i] = eth[8*(13 - i) +: 8];
    end
    for (int i = 0; i < 20; i++) begin
        body[14 + i] = iph[8*(19 - i) +: 8];
    end
    for (int i = 0; i < 8; i++) begin
        body[34 + i] = icmph[8*(7 - i) +: 8];
    end
    len = 42 + ((n > `MIN_PAYLOAD_BYTES) ? n : `MIN_PAYLOAD_BYTES);
    for (int i = 42; i < len; i++) begin
        body[i] = (i - 42 < n) ? payload[i - 42] : 8'h00;    // zero pad
    end
    crc = 32'hffff_ffff;
    for (int i = 0; i < len; i++) begin
        crc = crc_step(crc, body[i]);
    end
    fcs = reflect32(~crc);
    for (int i = 0; i < 7; i++) begin
        exp_bytes.push_back(8'h55);
    end
    exp_bytes.push_back(8'hd5);
    for (int i = 0; i < len; i++) begin
        exp_bytes.push_back(body[i]);
    end
    for (int i = 0; i < 4; i++) begin
        exp_bytes.push_back(fcs[8*i +: 8]);    // low byte first
    end
    exp_len_q.push_back(len + 12);
endfunction

`endif

//--- verification/icmp_echo_tx_tb.sv
`timescale 1ns/1ps
`include "icmp_echo_tx_params.svh"

module icmp_echo_tx_tb;

    localparam int n_long_frames    = 20;
    localparam int n_frames         = n_long_frames + 4;
    localparam int max_frame_cycles = 8 + 14 + 28 + 200 + 4;
    localparam int watchdog_cycles  = n_frames * max_frame_cycles * 2 + 1000;
    localparam int start_latency    = 8;    // falling edges from start to first beat

    logic        clk = 1'b0;
    logic        rst_n;
    logic        tx_start_en;
    logic [31:0] reply_checksum;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
    logic [15:0] tx_byte_num;
    logic [47:0] des_mac;
    logic [31:0] des_ip;
    logic [7:0]  tx_data;
    logic        tx_req;
    logic        tx_done;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;

    logic [7:0]  payload [0:255];
    logic [7:0]  exp_bytes [$];
    int          exp_len_q [$];
    int          exp_req_q [$];
    logic [15:0] ident_count;
    int          mismatches;
    int          failures;
    int          byte_count;
    int          req_count;
    int          frames_done;
    int          srv_idx;
    logic        req_pending;
    logic        en_prev;
    logic        done_prev;
    logic [7:0]  exp_byte;
    int          exp_val;

    `include "icmp_echo_tx_ref.svh"

    icmp_echo_tx dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_start_en    (tx_start_en),
        .reply_checksum (reply_checksum),
        .icmp_id        (icmp_id),
        .icmp_seq       (icmp_seq),
        .tx_byte_num    (tx_byte_num),
        .des_mac        (des_mac),
        .des_ip         (des_ip),
        .tx_data        (tx_data),
        .tx_req         (tx_req),
        .tx_done        (tx_done),
        .gmii_tx_en     (gmii_tx_en),
        .gmii_txd       (gmii_txd)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired, run did not finish in %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    // payload byte k goes out in the cycle after the k-th tx_req
    initial begin
        tx_data     = 8'h00;
        req_pending = 1'b0;
        srv_idx     = 0;
        forever begin
            @(negedge clk);
            if (req_pending) begin
                tx_data = payload[srv_idx];
                srv_idx++;
            end
            req_pending = rst_n && tx_req;
            if (tx_done) begin
                srv_idx = 0;
            end
        end
    end

    // **********************************************************************
    // compare gmii bytes and strobes against the expected frames
    // **********************************************************************
    always @(negedge clk) begin
        if (rst_n) begin
            if (tx_req) begin
                req_count++;
            end
            if (gmii_tx_en) begin
                byte_count++;
                if (exp_bytes.size() == 0) begin
                    $display("byte 0x%h sent on gmii_txd with no frame expected", gmii_txd);
                    failures++;
                end else begin
                    exp_byte = exp_bytes.pop_front();
                    if (gmii_txd !== exp_byte) begin
                        $display("mismatch gmii_txd frame %0d byte %0d: got 0x%h expected 0x%h",
                                 frames_done, byte_count - 1, gmii_txd, exp_byte);
                        mismatches++;
                    end
                end
            end
            if (tx_done) begin
                if (!(en_prev && !gmii_tx_en)) begin
                    $display("tx_done did not come right after the frame ended");
                    failures++;
                end
                if (done_prev) begin
                    $display("tx_done held high for more than one cycle");
                    failures++;
                end
                if (exp_len_q.size() == 0 || exp_req_q.size() == 0) begin
                    $display("tx_done pulsed with no frame outstanding");
                    failures++;
                end else begin
                    exp_val = exp_len_q.pop_front();
                    if (byte_count != exp_val) begin
                        $display("mismatch frame length: got 0x%h expected 0x%h",
                                 byte_count, exp_val);
                        mismatches++;
                    end
                    exp_val = exp_req_q.pop_front();
                    if (req_count != exp_val) begin
                        $display("mismatch tx_req cycles: got 0x%h expected 0x%h",
                                 req_count, exp_val);
                        mismatches++;
                    end
                end
                byte_count = 0;
                req_count  = 0;
                frames_done++;
            end
            en_prev   = gmii_tx_en;
            done_prev = tx_done;
        end
    end

    task automatic fill_payload(input int n);
        for (int k = 0; k < n; k++) begin
            payload[k] = 8'($urandom);
        end
    endtask

    // one request, optionally with a second start edge in the middle of the frame
    task automatic send_frame(input logic [47:0] mac, input logic [31:0] ip,
                              input logic [15:0] id, input logic [15:0] seq,
                              input int n, input bit busy_edge);
        int lat;
        int wait_cycles;
        int done_before;
        @(negedge clk);
        des_mac        = mac;
        des_ip         = ip;
        icmp_id        = id;
        icmp_seq       = seq;
        tx_byte_num    = 16'(n);
        reply_checksum = payload_word_sum(n);
        ident_count    = ident_count + 16'd1;
        expect_frame(mac, ip, id, seq, n, ident_count);
        exp_req_q.push_back(n);
        done_before = frames_done;
        tx_start_en = 1'b1;
        lat = 0;
        while (!gmii_tx_en && lat < 20) begin
            @(negedge clk);
            lat++;
            if (lat == 2) begin
                tx_start_en = 1'b0;
            end
        end
        tx_start_en = 1'b0;
        if (!gmii_tx_en) begin
            $display("frame %0d never started on gmii_tx_en", done_before);
            failures++;
        end else if (lat != start_latency) begin
            $display("mismatch start latency: got 0x%h expected 0x%h", lat, start_latency);
            mismatches++;
        end
        if (busy_edge) begin
            repeat (20) @(negedge clk);
            tx_start_en = 1'b1;    // must be ignored, frame still running
            repeat (2) @(negedge clk);
            tx_start_en = 1'b0;
        end
        wait_cycles = 0;
        while (frames_done == done_before && wait_cycles < max_frame_cycles + 50) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (frames_done == done_before) begin
            $display("no tx_done for frame %0d", done_before);
            failures++;
        end
        repeat (4) @(negedge clk);
    endtask

    initial begin : main_seq
        int n;
        void'($urandom(28));
        rst_n          = 1'b0;
        tx_start_en    = 1'b0;
        reply_checksum = '0;
        icmp_id        = '0;
        icmp_seq       = '0;
        tx_byte_num    = '0;
        des_mac        = '0;
        des_ip         = '0;
        ident_count    = '0;
        mismatches     = 0;
        failures       = 0;
        byte_count     = 0;
        req_count      = 0;
        frames_done    = 0;
        en_prev        = 1'b0;
        done_prev      = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // outputs quiet after reset
        if (gmii_tx_en !== 1'b0) begin
            $display("mismatch gmii_tx_en after reset: got 0x%h expected 0x0", gmii_tx_en);
            mismatches++;
        end
        if (tx_req !== 1'b0) begin
            $display("mismatch tx_req after reset: got 0x%h expected 0x0", tx_req);
            mismatches++;
        end
        if (tx_done !== 1'b0) begin
            $display("mismatch tx_done after reset: got 0x%h expected 0x0", tx_done);
            mismatches++;
        end
        if (gmii_txd !== 8'h00) begin
            $display("mismatch gmii_txd after reset: got 0x%h expected 0x00", gmii_txd);
            mismatches++;
        end

        fill_payload(5);    // 13 pad bytes
        send_frame(48'h02_11_22_33_44_55, 32'hc0_a8_01_64, 16'h1234, 16'h0001, 5, 1'b0);

        for (int f = 0; f < n_long_frames; f++) begin
            n = 18 + int'($urandom % 183);
            fill_payload(n);
            send_frame(48'({$urandom, $urandom}) | 48'd1, $urandom | 32'd1,
                       16'($urandom), 16'($urandom), n, 1'b0);
        end

        // default addresses, both fields and the mac alone
        fill_payload(30);
        send_frame(48'd0, 32'd0, 16'hbeef, 16'h0100, 30, 1'b0);
        fill_payload(9);
        send_frame(48'd0, 32'h0a_00_00_02, 16'h0042, 16'h0101, 9, 1'b0);

        fill_payload(40);
        send_frame(48'h02_aa_bb_cc_dd_ee, 32'h0a_00_00_07, 16'h7777, 16'h0200, 40, 1'b1);
        repeat (40) @(negedge clk);    // any extra frame shows up as unexpected bytes

        if (frames_done != n_frames) begin
            $display("saw %0d completed frames instead of %0d", frames_done, n_frames);
            failures++;
        end
        if (exp_bytes.size() != 0) begin
            $display("%0d expected bytes never appeared on gmii_txd", exp_bytes.size());
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- icmp_echo_tx.f
+incdir+design
+incdir+verification
design/icmp_echo_tx_pkg.sv
design/icmp_echo_tx_ctrl.sv
design/ones_sum_fold.sv
design/frame_header_gen.sv
design/eth_fcs_gen.sv
design/icmp_echo_tx.sv
verification/icmp_echo_tx_tb.sv

//--- Bender.yml
package:
  name: icmp_echo_tx

sources:
  - include_dirs:
      - design
    files:
      - design/icmp_echo_tx_pkg.sv
      - design/icmp_echo_tx_ctrl.sv
      - design/ones_sum_fold.sv
      - design/frame_header_gen.sv
      - design/eth_fcs_gen.sv
      - design/icmp_echo_tx.sv
  - target: simulation
    include_dirs:
      - design
      - verification
    files:
      - verification/icmp_echo_tx_tb.sv
